// ==== Makefile ====
# Verilator simulation of the sprite unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_ppu_sprite
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM_ARGS  ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		abort_run();
	end
endtask

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp);
	@(negedge clk);
	awvalid = 1'b1;
	wvalid = 1'b1;
	awaddr = addr;
	wdata = data;
	do begin
		@(negedge clk);
	end while (!awready);
	check_eq("wready", wready, 32'd1);
	awvalid = 1'b0;
	wvalid = 1'b0;
	while (!bvalid) @(negedge clk);
	check_eq("bresp", bresp, exp_resp);
endtask

task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
	@(negedge clk);
	arvalid = 1'b1;
	araddr = addr;
	do begin
		@(negedge clk);
	end while (!arready);
	arvalid = 1'b0;
	while (!rvalid) @(negedge clk);
	data = rdata;
	resp = rresp;
endtask

task automatic set_tileset(input logic [23:0] base, input int lps, input logic big);
	axi_write(32'h10, {4'h0, big, 3'(4 - lps), base}, 2'b00); // pixmode 0 is 16 bits.
	ts_base = base;
	ts_lps = lps;
	ts_big = big;
endtask

task automatic set_sprite(input int i, input int x, input int y, input int tile,
		input logic en);
	axi_write(32'(4 * i), {en, 3'b000, 8'(tile), 10'(y), 10'(x)}, 2'b00);
	spr_x[i] = x;
	spr_y[i] = y;
	spr_tile[i] = tile;
	spr_en[i] = en;
endtask

task automatic run_line(input int y);
	@(negedge clk);
	line_start = 1'b1;
	line_y = 10'(y);
	@(negedge clk);
	line_start = 1'b0;
	while (!line_ready) @(negedge clk);
	cur_y = y;
endtask

function automatic logic [15:0] sprite_pixel(input int tile, input int row, input int col);
	logic [31:0] idx;
	logic [31:0] bit_addr;
	logic [31:0] byte_addr;
	logic [31:0] word;
	if (ts_big) begin
		idx = 32'((tile << 8) | (row << 4) | col);
	end else begin
		idx = 32'((tile << 6) | (row << 3) | col);
	end
	bit_addr = idx << ts_lps;
	byte_addr = {ts_base, 8'h00} | (bit_addr >> 3);
	word = mem_word(byte_addr & ~32'h3);
	return 16'((word >> bit_addr[4:0]) & ((32'h1 << (1 << ts_lps)) - 32'h1));
endfunction

// lane 0 has the highest priority, a zero pixel lets the next lane through.
function automatic logic [15:0] expect_pixel(input int x);
	int size;
	logic [15:0] res;
	logic found;
	size = ts_big ? 16 : 8;
	res = '0;
	found = 1'b0;
	for (int i = 0; i < n_sprite; i++) begin
		if (!found && spr_en[i] && cur_y < spr_y[i] && cur_y + size >= spr_y[i]
				&& x < spr_x[i] && x + size >= spr_x[i]) begin
			res = sprite_pixel(spr_tile[i], cur_y - spr_y[i] + size, x - spr_x[i] + size);
			found = res != '0;
		end
	end
	return res;
endfunction

task automatic check_pixel(input int x, input logic [15:0] exp);
	@(negedge clk);
	pix_vld = 1'b1;
	pix_x = 10'(x);
	@(negedge clk);
	pix_vld = 1'b0;
	check_eq("out_vld", out_vld, 32'd1);
	check_eq("out_pix", out_pix, exp);
endtask

task automatic sweep_pixels(input int x_lo, input int x_hi);
	int x;
	for (x = x_lo; x <= x_hi; x++) begin
		check_pixel(x, expect_pixel(x));
		if (replay_mode == 1) begin
			saved_pix[pix_cnt] = out_pix;
		end else if (replay_mode == 2) begin
			check_eq("out_pix against first run", out_pix, saved_pix[pix_cnt]);
		end
		pix_cnt++;
	end
endtask

`endif

// ==== bench/tb_ppu_sprite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_sprite;
	import ppu_pkg::*;

	localparam int timeout_cycles = 20000; // tests take about 1500 cycles.

	logic clk;
	logic rst_n;
	logic awvalid;
	logic wvalid;
	logic bready;
	logic arvalid;
	logic rready;
	logic awready;
	logic wready;
	logic bvalid;
	logic arready;
	logic rvalid;
	logic [w_addr-1:0] awaddr;
	logic [w_addr-1:0] araddr;
	logic [w_data-1:0] wdata;
	logic [w_data-1:0] rdata;
	logic [w_data/8-1:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic line_start;
	logic [w_coord-1:0] line_y;
	logic line_ready;
	logic pix_vld;
	logic [w_coord-1:0] pix_x;
	logic out_vld;
	logic [w_pix-1:0] out_pix;
	logic mem_vld;
	logic [w_addr-1:0] mem_addr;
	logic mem_rdy = 1'b1;
	logic [w_data-1:0] mem_rdata;

	integer seed = 32'hdded_f6df;
	integer rnd;
	logic force_rdy = 1'b1;
	logic stall_q = 1'b0;
	logic [w_addr-1:0] addr_q = '0;
	int vld_cnt = 0;
	int stall_cnt = 0;
	int cycle_cnt = 0;

	int spr_x [n_sprite];
	int spr_y [n_sprite];
	int spr_tile [n_sprite];
	logic spr_en [n_sprite];
	logic [23:0] ts_base;
	int ts_lps;
	logic ts_big;
	int cur_y;
	logic [15:0] saved_pix [256];
	int pix_cnt;
	int replay_mode; // 1 records the pixels, 2 compares against the record.

	ppu_sprite_top UUT (.*);

	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	`include "tb_tasks.svh"

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ {addr[18:0], addr[31:19]}; // address xor itself rotated by 13.
	endfunction

	assign mem_rdata = mem_word(mem_addr);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(negedge clk) begin
		rnd = $random(seed);
		mem_rdy = force_rdy || (rnd[1:0] == 2'b00);
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			abort_run();
		end
	end

	// a request stalled by mem_rdy must come back unchanged.
	always @(posedge clk) begin
		if (rst_n) begin
			if (stall_q) begin
				check_eq("mem_vld", mem_vld, 32'd1);
				check_eq("mem_addr", mem_addr, addr_q);
			end
			stall_q <= mem_vld && !mem_rdy;
			addr_q <= mem_addr;
			vld_cnt <= vld_cnt + int'(mem_vld);
			stall_cnt <= stall_cnt + int'(mem_vld && !mem_rdy);
		end
	end

	function automatic logic [31:0] reg_pattern(input int i);
		return 32'h9e37_79b9 * 32'(i + 1);
	endfunction

	task automatic register_readback();
		logic [31:0] data;
		logic [1:0] resp;
		int i;
		for (i = 0; i <= n_sprite; i++) begin
			axi_write(32'(4 * i), reg_pattern(i), 2'b00);
		end
		for (i = 0; i <= n_sprite; i++) begin
			axi_read(32'(4 * i), data, resp);
			check_eq("rresp", resp, 2'b00);
			check_eq("rdata", data, reg_pattern(i));
		end
		axi_read(32'h20, data, resp);
		check_eq("rresp", resp, 2'b10);
		axi_write(32'h14, 32'hffff_ffff, 2'b10);
		axi_read(32'h10, data, resp);
		check_eq("rdata", data, reg_pattern(n_sprite));
		wstrb = 4'b0101; // only bytes 0 and 2 are written.
		axi_write(32'h0, 32'h0, 2'b00);
		wstrb = 4'hf;
		axi_read(32'h0, data, resp);
		check_eq("rdata", data, reg_pattern(0) & 32'hff00_ff00);
	endtask

	task automatic configure_single();
		int i;
		set_tileset(24'h000012, 3, 1'b0);
		set_sprite(0, 40, 30, 5, 1'b1); // covers x 32 to 39 and y 22 to 29.
		for (i = 1; i < n_sprite; i++) begin
			set_sprite(i, 0, 0, 0, 1'b0);
		end
	endtask

	task automatic run_single_lines();
		pix_cnt = 0;
		run_line(22);
		sweep_pixels(28, 44);
		run_line(25);
		sweep_pixels(28, 44);
		run_line(29);
		sweep_pixels(28, 44);
	endtask

	task automatic empty_line();
		int vld_before;
		configure_single();
		vld_before = vld_cnt;
		run_line(100);
		check_eq("mem_vld cycles", 32'(vld_cnt - vld_before), 32'd0);
		sweep_pixels(20, 60);
	endtask

	task automatic single_sprite();
		configure_single();
		replay_mode = 1;
		run_single_lines();
		replay_mode = 0;
	endtask

	task automatic overlapping_sprites();
		set_tileset(24'h000000, 2, 1'b0);
		set_sprite(0, 40, 30, 0, 1'b1);
		set_sprite(1, 43, 30, 1, 1'b1);
		set_sprite(2, 0, 0, 0, 1'b0);
		set_sprite(3, 0, 0, 0, 1'b0);
		run_line(23);
		sweep_pixels(30, 44);
		check_pixel(35, 16'h8); // both opaque, lane 0 wins.
		check_pixel(36, 16'h2); // lane 0 is zero here.
	endtask

	task automatic big_tiles();
		int lps;
		for (lps = 2; lps <= 4; lps += 2) begin
			set_tileset(24'h000040, lps, 1'b1);
			set_sprite(0, 0, 0, 0, 1'b0);
			set_sprite(1, 0, 0, 0, 1'b0);
			set_sprite(2, 100, 60, 3, 1'b1);
			set_sprite(3, 130, 55, 8'h21, 1'b1);
			run_line(44);
			sweep_pixels(82, 131);
			run_line(50);
			sweep_pixels(82, 131);
			run_line(59);
			sweep_pixels(82, 131);
		end
	endtask

	task automatic memory_stalls();
		int stalls_before;
		force_rdy = 1'b0;
		configure_single();
		stalls_before = stall_cnt;
		replay_mode = 2;
		run_single_lines();
		replay_mode = 0;
		force_rdy = 1'b1;
		check_eq("stall cycles seen", 32'(stall_cnt > stalls_before), 32'd1);
	endtask

	initial begin
		rst_n = 1'b0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		arvalid = 1'b0;
		rready = 1'b1;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = 4'hf;
		line_start = 1'b0;
		line_y = '0;
		pix_vld = 1'b0;
		pix_x = '0;
		replay_mode = 0;
		pix_cnt = 0;
		cur_y = 0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_eq("mem_vld", mem_vld, 32'd0);
		check_eq("line_ready", line_ready, 32'd0);
		check_eq("out_vld", out_vld, 32'd0);
		check_eq("bvalid", bvalid, 32'd0);
		check_eq("rvalid", rvalid, 32'd0);
		register_readback();
		empty_line();
		single_sprite();
		overlapping_sprites();
		big_tiles();
		memory_stalls();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/ppu_pkg.sv ====
`default_nettype none

package ppu_pkg;

	localparam int n_sprite = 4;
	localparam int w_coord = 10;
	localparam int w_data = 32;
	localparam int w_addr = 32;
	localparam int w_pix = 16;
	localparam int max_row_words = 8; // 16 pixels of 16 bits.
	localparam int w_byte_sel = $clog2(w_data / 8);

	localparam logic [w_addr-1:0] reg_sprite_base = 32'h0000_0000;
	localparam logic [w_addr-1:0] reg_ts_addr = 32'h0000_0010;

	typedef struct packed {
		logic               enable;
		logic [7:0]         tile;
		logic [w_coord-1:0] pos_y;
		logic [w_coord-1:0] pos_x;
	} sprite_cfg_t;

	typedef struct packed {
		logic [23:0] tsbase;
		logic [2:0]  pixmode;
		logic        tilesize; // 0 selects 8x8 tiles, 1 selects 16x16.
	} ts_cfg_t;

	typedef struct packed {
		logic               hit;
		logic [3:0]         row;
		logic [w_coord-1:0] x_left;
	} coord_rsp_t;

	typedef struct packed {
		logic [7:0] tile;
		logic [3:0] row;
		logic [3:0] u; // first pixel column held by the word.
	} fetch_req_t;

	function automatic logic [2:0] log_pixsize(input logic [2:0] pixmode);
		logic [2:0] res;
		case (pixmode)
			3'd0: res = 3'd4;
			3'd1: res = 3'd3;
			3'd2: res = 3'd2;
			3'd3: res = 3'd1;
			3'd4: res = 3'd0;
			default: res = 3'd3;
		endcase
		return res;
	endfunction

	function automatic logic [4:0] tile_size(input logic tilesize);
		return tilesize ? 5'd16 : 5'd8;
	endfunction

endpackage

`default_nettype wire

// ==== hw/ppu_sprite_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_sprite_regs (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          awvalid,
	output logic                                          awready,
	input  logic [ppu_pkg::w_addr-1:0]                    awaddr,
	input  logic                                          wvalid,
	output logic                                          wready,
	input  logic [ppu_pkg::w_data-1:0]                    wdata,
	input  logic [ppu_pkg::w_data/8-1:0]                  wstrb,
	output logic                                          bvalid,
	input  logic                                          bready,
	output logic [1:0]                                    bresp,
	input  logic                                          arvalid,
	output logic                                          arready,
	input  logic [ppu_pkg::w_addr-1:0]                    araddr,
	output logic                                          rvalid,
	input  logic                                          rready,
	output logic [ppu_pkg::w_data-1:0]                    rdata,
	output logic [1:0]                                    rresp,
	output ppu_pkg::sprite_cfg_t [ppu_pkg::n_sprite-1:0] sprite_cfg,
	output ppu_pkg::ts_cfg_t                              ts_cfg
);
	import ppu_pkg::*;

	logic [w_data-1:0] regs_q [n_sprite+1]; // the last entry is the tileset word.
	logic [3:0] wr_map;
	logic [3:0] rd_map;

	// returns a valid bit above the register index.
	function automatic logic [3:0] decode(input logic [w_addr-1:0] addr);
		logic [3:0] res;
		res = 4'h0;
		for (int i = 0; i < n_sprite; i++) begin
			if ({addr[w_addr-1:2], 2'b00} == reg_sprite_base + w_addr'(4 * i)) begin
				res = {1'b1, 3'(i)};
			end
		end
		if ({addr[w_addr-1:2], 2'b00} == reg_ts_addr) begin
			res = {1'b1, 3'(n_sprite)};
		end
		return res;
	endfunction

	assign wr_map = decode(awaddr);
	assign rd_map = decode(araddr);
	assign wready = awready; // address and data are always taken in the same cycle.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			for (int i = 0; i <= n_sprite; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			arready <= arvalid && !arready && !rvalid;
			if (awready) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
			if (awready && wr_map[3]) begin
				for (int b = 0; b < w_data / 8; b++) begin
					if (wstrb[b]) begin
						regs_q[wr_map[2:0]][8*b +: 8] <= wdata[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (awready) begin
			bresp <= wr_map[3] ? 2'b00 : 2'b10; // slverr for an unmapped offset.
		end
		if (arready) begin
			rdata <= rd_map[3] ? regs_q[rd_map[2:0]] : '0;
			rresp <= rd_map[3] ? 2'b00 : 2'b10;
		end
	end

	always_comb begin
		for (int i = 0; i < n_sprite; i++) begin
			sprite_cfg[i].pos_x = regs_q[i][9:0];
			sprite_cfg[i].pos_y = regs_q[i][19:10];
			sprite_cfg[i].tile = regs_q[i][27:20];
			sprite_cfg[i].enable = regs_q[i][31];
		end
		ts_cfg.tsbase = regs_q[n_sprite][23:0];
		ts_cfg.pixmode = regs_q[n_sprite][26:24];
		ts_cfg.tilesize = regs_q[n_sprite][27];
	end

endmodule

`default_nettype wire

// ==== hw/ppu_sprite_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ppu_sprite_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [ppu_pkg::w_addr-1:0]    awaddr,
	input  logic                          wvalid,
	output logic                          wready,
	input  logic [ppu_pkg::w_data-1:0]    wdata,
	input  logic [ppu_pkg::w_data/8-1:0]  wstrb,
	output logic                          bvalid,
	input  logic                          bready,
	output logic [1:0]                    bresp,
	input  logic                          arvalid,
	output logic                          arready,
	input  logic [ppu_pkg::w_addr-1:0]    araddr,
	output logic                          rvalid,
	input  logic                          rready,
	output logic [ppu_pkg::w_data-1:0]    rdata,
	output logic [1:0]                    rresp,
	input  logic                          line_start,
	input  logic [ppu_pkg::w_coord-1:0]   line_y,
	output logic                          line_ready,
	input  logic                          pix_vld,
	input  logic [ppu_pkg::w_coord-1:0]   pix_x,
	output logic                          out_vld,
	output logic [ppu_pkg::w_pix-1:0]     out_pix,
	output logic                          mem_vld,
	output logic [ppu_pkg::w_addr-1:0]    mem_addr,
	input  logic                          mem_rdy,
	input  logic [ppu_pkg::w_data-1:0]    mem_rdata
);
	import ppu_pkg::*;

	sprite_cfg_t [n_sprite-1:0] sprite_cfg;
	ts_cfg_t ts_cfg;
	logic [n_sprite-1:0] coord_req;
	logic [n_sprite-1:0] coord_ack;
	coord_rsp_t coord_rsp;
	logic [n_sprite-1:0] fetch_vld;
	fetch_req_t [n_sprite-1:0] fetch_req;
	logic [n_sprite-1:0] fetch_rdy;
	logic [w_data-1:0] fetch_data;
	logic [n_sprite-1:0] lane_done;
	logic [n_sprite-1:0] lane_opaque;
	logic [n_sprite-1:0][w_pix-1:0] lane_value;

	ppu_sprite_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awready    (awready),
		.awaddr     (awaddr),
		.wvalid     (wvalid),
		.wready     (wready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.bvalid     (bvalid),
		.bready     (bready),
		.bresp      (bresp),
		.arvalid    (arvalid),
		.arready    (arready),
		.araddr     (araddr),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rresp      (rresp),
		.sprite_cfg (sprite_cfg),
		.ts_cfg     (ts_cfg)
	);

	sprite_coord_unit u_coord (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_y     (line_y),
		.sprite_cfg (sprite_cfg),
		.ts_cfg     (ts_cfg),
		.coord_req  (coord_req),
		.coord_ack  (coord_ack),
		.coord_rsp  (coord_rsp)
	);

	sprite_fetch_unit u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.ts_cfg     (ts_cfg),
		.fetch_vld  (fetch_vld),
		.fetch_req  (fetch_req),
		.fetch_rdy  (fetch_rdy),
		.mem_vld    (mem_vld),
		.mem_addr   (mem_addr),
		.mem_rdy    (mem_rdy),
		.mem_rdata  (mem_rdata),
		.fetch_data (fetch_data)
	);

	for (genvar i = 0; i < n_sprite; i++) begin : g_lane
		sprite_lane u_lane (
			.clk        (clk),
			.rst_n      (rst_n),
			.cfg        (sprite_cfg[i]),
			.ts_cfg     (ts_cfg),
			.line_start (line_start),
			.coord_req  (coord_req[i]),
			.coord_ack  (coord_ack[i]),
			.coord_rsp  (coord_rsp),
			.fetch_vld  (fetch_vld[i]),
			.fetch_req  (fetch_req[i]),
			.fetch_rdy  (fetch_rdy[i]),
			.fetch_data (fetch_data),
			.done       (lane_done[i]),
			.pix_vld    (pix_vld),
			.pix_x      (pix_x),
			.pix_opaque (lane_opaque[i]),
			.pix_value  (lane_value[i])
		);
	end

	sprite_compositor u_comp (
		.clk         (clk),
		.rst_n       (rst_n),
		.pix_vld     (pix_vld),
		.lane_opaque (lane_opaque),
		.lane_value  (lane_value),
		.out_vld     (out_vld),
		.out_pix     (out_pix)
	);

	assign line_ready = &lane_done;

endmodule

`default_nettype wire

// ==== hw/sprite_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_compositor (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           pix_vld,
	input  logic [ppu_pkg::n_sprite-1:0]                   lane_opaque,
	input  logic [ppu_pkg::n_sprite-1:0][ppu_pkg::w_pix-1:0] lane_value,
	output logic                                           out_vld,
	output logic [ppu_pkg::w_pix-1:0]                      out_pix
);
	import ppu_pkg::*;

	logic [w_pix-1:0] pix_sel;

	// walk down from the top so the lowest opaque lane is left standing.
	always_comb begin
		pix_sel = '0;
		for (int i = n_sprite - 1; i >= 0; i--) begin
			if (lane_opaque[i]) begin
				pix_sel = lane_value[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_vld <= 1'b0;
		end else begin
			out_vld <= pix_vld;
		end
	end

	always_ff @(posedge clk) begin
		out_pix <= pix_sel; // zero when no lane is opaque.
	end

endmodule

`default_nettype wire

// ==== hw/sprite_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_lane (
	input  logic                         clk,
	input  logic                         rst_n,
	input  ppu_pkg::sprite_cfg_t         cfg,
	input  ppu_pkg::ts_cfg_t             ts_cfg,
	input  logic                         line_start,
	output logic                         coord_req,
	input  logic                         coord_ack,
	input  ppu_pkg::coord_rsp_t          coord_rsp,
	output logic                         fetch_vld,
	output ppu_pkg::fetch_req_t          fetch_req,
	input  logic                         fetch_rdy,
	input  logic [ppu_pkg::w_data-1:0]   fetch_data,
	output logic                         done,
	input  logic                         pix_vld,
	input  logic [ppu_pkg::w_coord-1:0]  pix_x,
	output logic                         pix_opaque,
	output logic [ppu_pkg::w_pix-1:0]    pix_value
);
	import ppu_pkg::*;

	typedef enum logic [1:0] {st_idle, st_ask, st_fetch, st_done} state_t;

	state_t state;
	logic hit_q;
	logic [3:0] row_q;
	logic [w_coord-1:0] x_left_q;
	logic [2:0] word_cnt;
	logic [2:0] last_word;
	logic [max_row_words-1:0][w_data-1:0] row_buf;
	logic [2:0] lps;
	logic [4:0] size;
	logic [3:0] log_row_bits;
	logic [7:0] row_pix;
	logic [4:0] row_off;
	logic [w_coord-1:0] col;
	logic [7:0] bit_pos;
	logic [max_row_words*w_data-1:0] shifted;
	logic [w_pix-1:0] pix_mask;

	assign lps = log_pixsize(ts_cfg.pixmode);
	assign size = tile_size(ts_cfg.tilesize);
	assign log_row_bits = 4'd3 + {3'd0, ts_cfg.tilesize} + {1'b0, lps};
	assign last_word = (log_row_bits > 4'd5) ?
		3'((4'd1 << (log_row_bits - 4'd5)) - 4'd1) : 3'd0;

	assign coord_req = state == st_ask;
	assign fetch_vld = state == st_fetch;
	assign done = state == st_done;
	assign fetch_req.tile = cfg.tile;
	assign fetch_req.row = row_q;
	assign fetch_req.u = {1'b0, word_cnt} << (3'd5 - lps);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			hit_q <= 1'b0;
			word_cnt <= '0;
		end else begin
			case (state)
				st_idle, st_done: begin
					if (line_start) begin
						hit_q <= 1'b0;
						word_cnt <= '0;
						state <= cfg.enable ? st_ask : st_done;
					end
				end
				st_ask: begin
					if (coord_ack) begin
						hit_q <= coord_rsp.hit;
						state <= coord_rsp.hit ? st_fetch : st_done;
					end
				end
				default: begin
					if (fetch_rdy) begin
						if (word_cnt == last_word) begin
							state <= st_done;
						end else begin
							word_cnt <= word_cnt + 3'd1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_ask && coord_ack) begin
			row_q <= coord_rsp.row;
			x_left_q <= coord_rsp.x_left;
		end
		if (state == st_fetch && fetch_rdy) begin
			row_buf[word_cnt] <= fetch_data;
		end
	end

	// a row narrower than a word sits at a bit offset inside it.
	assign row_pix = ts_cfg.tilesize ? {row_q, 4'h0} : {2'b00, row_q[2:0], 3'b000};
	assign row_off = 5'(row_pix << lps);
	assign col = pix_x - x_left_q;
	assign bit_pos = {3'b000, row_off} + ({4'h0, col[3:0]} << lps);
	assign shifted = row_buf >> bit_pos;
	assign pix_mask = w_pix'((17'h1 << (5'd1 << lps)) - 17'h1);
	assign pix_value = shifted[w_pix-1:0] & pix_mask;

	assign pix_opaque = pix_vld && done && hit_q && (col < {5'b00000, size})
		&& (pix_value != '0);

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
common/ppu_pkg.sv
hw/ppu_sprite_regs.sv
sprite_agu/sprite_coord_unit.sv
sprite_agu/sprite_fetch_unit.sv
hw/sprite_lane.sv
hw/sprite_compositor.sv
hw/ppu_sprite_top.sv
bench/tb_ppu_sprite.sv

// ==== sprite_agu/sprite_coord_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_coord_unit (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic [ppu_pkg::w_coord-1:0]                   line_y,
	input  ppu_pkg::sprite_cfg_t [ppu_pkg::n_sprite-1:0] sprite_cfg,
	input  ppu_pkg::ts_cfg_t                              ts_cfg,
	input  logic [ppu_pkg::n_sprite-1:0]                  coord_req,
	output logic [ppu_pkg::n_sprite-1:0]                  coord_ack,
	output ppu_pkg::coord_rsp_t                           coord_rsp
);
	import ppu_pkg::*;

	logic [w_coord-1:0] beam_y;
	logic [w_coord-1:0] pos_x;
	logic [w_coord-1:0] pos_y;
	logic [w_coord-1:0] size;
	logic [w_coord-1:0] row_full;
	logic [w_coord:0] y_reach;

	// sampled only while no lane is asking, so it keeps the line_start value.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beam_y <= '0;
		end else if (~|coord_req) begin
			beam_y <= line_y;
		end
	end

	assign coord_ack = coord_req & (~coord_req + 1'b1); // lowest index wins.

	always_comb begin
		pos_x = '0;
		pos_y = '0;
		for (int i = 0; i < n_sprite; i++) begin
			pos_x = pos_x | ({w_coord{coord_ack[i]}} & sprite_cfg[i].pos_x);
			pos_y = pos_y | ({w_coord{coord_ack[i]}} & sprite_cfg[i].pos_y);
		end
	end

	assign size = w_coord'(tile_size(ts_cfg.tilesize));
	assign y_reach = {1'b0, beam_y} + {1'b0, size};
	assign row_full = beam_y + size - pos_y;

	// pos_y is the row just below the sprite.
	assign coord_rsp.hit = (beam_y < pos_y) && (y_reach >= {1'b0, pos_y});
	assign coord_rsp.row = row_full[3:0];
	assign coord_rsp.x_left = pos_x - size;

endmodule

`default_nettype wire

// ==== sprite_agu/sprite_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_fetch_unit (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  ppu_pkg::ts_cfg_t                             ts_cfg,
	input  logic [ppu_pkg::n_sprite-1:0]                 fetch_vld,
	input  ppu_pkg::fetch_req_t [ppu_pkg::n_sprite-1:0] fetch_req,
	output logic [ppu_pkg::n_sprite-1:0]                 fetch_rdy,
	output logic                                         mem_vld,
	output logic [ppu_pkg::w_addr-1:0]                   mem_addr,
	input  logic                                         mem_rdy,
	input  logic [ppu_pkg::w_data-1:0]                   mem_rdata,
	output logic [ppu_pkg::w_data-1:0]                   fetch_data
);
	import ppu_pkg::*;

	logic [n_sprite-1:0] gnt_comb;
	logic [n_sprite-1:0] gnt_q;
	logic [n_sprite-1:0] gnt;
	fetch_req_t req;
	logic [2:0] lps;
	logic [w_addr-1:0] pix_idx;

	assign gnt_comb = fetch_vld & (~fetch_vld + 1'b1);
	assign gnt = |gnt_q ? gnt_q : gnt_comb;

	// a stalled grant is kept until its word is accepted.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_q <= '0;
		end else begin
			gnt_q <= mem_rdy ? '0 : gnt;
		end
	end

	always_comb begin
		req = '0;
		for (int i = 0; i < n_sprite; i++) begin
			if (gnt[i]) begin
				req = req | fetch_req[i];
			end
		end
	end

	assign lps = log_pixsize(ts_cfg.pixmode);

	assign pix_idx = ts_cfg.tilesize ?
		{{(w_addr-16){1'b0}}, req.tile, req.row, req.u} :
		{{(w_addr-14){1'b0}}, req.tile, req.row[2:0], req.u[2:0]};

	// pixel index scaled to bits, then to bytes, then down to the bus word.
	assign mem_addr = ({ts_cfg.tsbase, 8'h00} | ((pix_idx << lps) >> 3))
		& ({w_addr{1'b1}} << w_byte_sel);

	assign mem_vld = |gnt;
	assign fetch_rdy = gnt & {n_sprite{mem_rdy}};
	assign fetch_data = mem_rdata;

endmodule

`default_nettype wire
